// File: src.f
core_pkg.sv
fe_pkg.sv
bpu.sv
imem_bank.sv
fetch_merge.sv
fe_ctl.sv
frontend_top.sv
frontend_sva.sv
frontend_tb.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -f src.f --top-module frontend_tb -o frontend_sim &&
    ./obj_dir/frontend_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "No errors" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: frontend_tb.sv
`timescale 1ns/100ps

module frontend_tb;

    localparam int M_IDLE    = 0;
    localparam int M_REQ     = 1;
    localparam int M_PDG     = 2;
    localparam int SEQ_CYC   = 150;
    localparam int ROUNDS    = 8;
    localparam int ROUND_CYC = 24;   // Longest recovery round
    localparam int TOTAL_CYC = 17 + 64 + 2 * SEQ_CYC + 2 * ROUNDS * ROUND_CYC + 270;

    logic        clk;
    logic        reset;
    logic        load_en;
    logic [31:0] load_addr;
    logic [31:0] load_data;
    logic        nuke;
    logic        resume_fetch;
    logic [4:0]  oldest_robid;
    logic        br_mispred_valid;
    logic [4:0]  br_mispred_robid;
    logic [31:0] br_mispred_restore_pc;
    logic        decode_ready;
    logic        valid_fe1;
    logic [31:0] instr_fe1;
    logic [31:0] pc_fe1;
    logic [31:0] pc_nxt_fe1;

    // Reference model, one entry per word of the bank space
    logic [31:0] mirror [64];
    int          jal_ofs [64];  // Byte offset each JAL was built with
    logic [31:0] m_pc;
    int          m_state;
    logic        m_nuke_pdg;
    logic        m_mp_pdg;
    logic [4:0]  m_held;
    logic [4:0]  m_oldest;
    logic        xfer;        // Instruction moved to decode in the last cycle
    logic [31:0] xfer_pc;
    logic [31:0] xfer_word;

    logic [31:0] lfsr = 32'hb5d4_6641;
    string       cur_test;
    int          n_tests;
    int          n_checks;
    int          n_errs;
    int          t_checks;
    int          t_errs;

    frontend_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic logic rand_ready();
        return take_bits(2) != 32'd0;  // Ready three cycles in four
    endfunction

    // Distance from the oldest id, modulo the 32 ids
    function automatic logic is_older(input logic [4:0] a, input logic [4:0] b,
                                      input logic [4:0] oldest);
        int da;
        int db;
        da = (int'(a) - int'(oldest) + 32) % 32;
        db = (int'(b) - int'(oldest) + 32) % 32;
        return da < db;
    endfunction

    function automatic logic [31:0] make_jal(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // Random word, about one in eight a JAL to another word of the window
    function automatic logic [31:0] random_word(input int idx, output int ofs);
        logic [31:0] w;
        int          t;
        ofs = 0;
        w = take_bits(32);
        if (take_bits(3) == 32'd0) begin
            t = int'(take_bits(6));
            if (t == idx) begin
                t = idx ^ 1;
            end
            ofs = (t - idx) * 4;
            w = make_jal(21'(ofs), 5'(take_bits(5)));
        end else if (w[6:0] == 7'b1101111) begin
            w[6:0] = 7'b0010011;
        end
        return w;
    endfunction

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        t_checks++;
        if (exp !== act) begin
            $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
            n_errs++;
            t_errs++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("%s: %s", cur_test, msg);
        n_errs++;
        t_errs++;
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        t_checks = 0;
        t_errs   = 0;
    endtask

    task automatic end_test();
        $display("[DONE] %s: %0d checks, %0d mismatches", cur_test, t_checks, t_errs);
        n_tests++;
    endtask

    // One clock cycle, entered and left on a rising edge
    task automatic cycle(input logic rdy, input logic mp_v, input logic [4:0] mp_id,
                         input logic [31:0] mp_pc, input logic nk, input logic rs);
        logic        exp_valid;
        logic        m_xfer;
        logic        ql;
        logic [31:0] word;
        logic [31:0] exp_nxt;
        #1;
        decode_ready          = rdy;
        br_mispred_valid      = mp_v;
        br_mispred_robid      = mp_id;
        br_mispred_restore_pc = mp_pc;
        nuke                  = nk;
        resume_fetch          = rs;
        oldest_robid          = m_oldest;
        load_en               = 1'b0;
        #4;
        word      = mirror[m_pc[7:2]];
        exp_valid = (m_state == M_REQ) && !m_nuke_pdg;
        ql        = mp_v && (!m_mp_pdg || is_older(mp_id, m_held, m_oldest));
        m_xfer    = exp_valid && rdy;
        xfer      = valid_fe1 && rdy;  // As seen at the DUT outputs
        xfer_pc   = pc_fe1;
        xfer_word = instr_fe1;
        compare("valid_fe1", 32'(exp_valid), 32'(valid_fe1));
        if (exp_valid) begin
            compare("pc_fe1", m_pc, pc_fe1);
            compare("instr_fe1", word, instr_fe1);
        end
        if (ql) begin
            exp_nxt = mp_pc;
        end else if (m_xfer && word[6:0] == 7'b1101111) begin
            exp_nxt = m_pc + 32'(jal_ofs[m_pc[7:2]]);  // Where this JAL was aimed
        end else if (m_xfer) begin
            exp_nxt = m_pc + 32'd4;
        end else begin
            exp_nxt = m_pc;
        end
        compare("pc_nxt_fe1", exp_nxt, pc_nxt_fe1);
        if (m_state == M_IDLE || (m_state == M_PDG && rs)) begin
            m_state = M_REQ;
        end else if (m_state == M_REQ && (m_nuke_pdg || nk)) begin
            m_state = M_PDG;
        end
        m_nuke_pdg = (m_nuke_pdg && !nk) || ql;
        m_mp_pdg   = !nk && (m_mp_pdg || ql);
        if (ql) begin
            m_held = mp_id;
        end
        m_pc = exp_nxt;
        @(posedge clk);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            cycle(rand_ready(), 1'b0, 5'd0, 32'd0, 1'b0, 1'b0);
        end
    endtask

    task automatic load_word(input int idx, input logic [31:0] data, input int ofs);
        #1;
        load_en      = 1'b1;
        load_addr    = 32'h100 + 32'(idx * 4);
        load_data    = data;
        decode_ready = 1'b0;
        mirror[idx]  = data;
        jal_ofs[idx] = ofs;
        @(posedge clk);
    endtask

    // Mispredict, nuke, resume, then look at the first PC sent to decode
    task automatic recover(input logic two);
        logic [4:0]  id1;
        logic [4:0]  id2;
        logic [31:0] pc1;
        logic [31:0] pc2;
        logic [31:0] exp_pc;
        logic        got;
        idle_cycles(4 + int'(take_bits(3)));
        m_oldest = 5'(take_bits(5));
        id1      = 5'(take_bits(5));
        id2      = 5'(take_bits(5));
        pc1      = 32'h100 + (take_bits(6) << 2);
        pc2      = 32'h100 + (take_bits(6) << 2);
        exp_pc   = pc1;
        cycle(rand_ready(), 1'b1, id1, pc1, 1'b0, 1'b0);
        if (two) begin
            cycle(rand_ready(), 1'b1, id2, pc2, 1'b0, 1'b0);
            if (is_older(id2, id1, m_oldest)) begin
                exp_pc = pc2;  // Younger one is overridden
            end
        end
        idle_cycles(3);
        cycle(rand_ready(), 1'b0, 5'd0, 32'd0, 1'b1, 1'b0);
        idle_cycles(2);
        cycle(1'b1, 1'b0, 5'd0, 32'd0, 1'b0, 1'b1);
        got = 1'b0;
        repeat (4) begin
            cycle(1'b1, 1'b0, 5'd0, 32'd0, 1'b0, 1'b0);
            if (xfer && !got) begin
                compare("restart pc", exp_pc, xfer_pc);
                got = 1'b1;
            end
        end
        if (!got) begin
            note_failure("no instruction reached decode after resume");
        end
    endtask

    initial begin
        int          jal_seen;
        int          stride;
        int          visited;
        int          n_cyc;
        int          ofs;
        logic [31:0] word;
        logic [63:0] seen;
        reset                 = 1'b1;
        load_en               = 1'b0;
        load_addr             = '0;
        load_data             = '0;
        nuke                  = 1'b0;
        resume_fetch          = 1'b0;
        oldest_robid          = '0;
        br_mispred_valid      = 1'b0;
        br_mispred_robid      = '0;
        br_mispred_restore_pc = '0;
        decode_ready          = 1'b0;
        m_oldest              = '0;
        m_held                = '0;
        n_tests               = 0;
        n_checks              = 0;
        n_errs                = 0;
        repeat (16) @(posedge clk);

        start_test("reset_load");
        #1;
        reset = 1'b0;
        #4;
        compare("valid_fe1", 32'd0, 32'(valid_fe1));
        compare("pc_nxt_fe1", core_pkg::BOOT_PC, pc_nxt_fe1);
        @(posedge clk);
        m_state    = M_REQ;
        m_pc       = core_pkg::BOOT_PC;
        m_nuke_pdg = 1'b0;
        m_mp_pdg   = 1'b0;
        for (int i = 0; i < 64; i++) begin
            word = random_word(i, ofs);
            load_word(i, word, ofs);
        end
        end_test();

        start_test("seq_fetch");
        idle_cycles(SEQ_CYC);
        end_test();

        start_test("jal_predict");
        jal_seen = 0;
        repeat (SEQ_CYC) begin
            cycle(1'b1, 1'b0, 5'd0, 32'd0, 1'b0, 1'b0);
            if (xfer && xfer_word[6:0] == 7'b1101111) begin
                jal_seen++;
            end
        end
        if (jal_seen == 0) begin
            note_failure("no JAL was sent to decode");
        end
        end_test();

        start_test("mispredict");
        repeat (ROUNDS) recover(1'b0);
        end_test();

        start_test("age_order");
        repeat (ROUNDS) recover(1'b1);
        end_test();

        // Halt fetch, reload as one jump cycle over all 64 words
        start_test("interleave");
        stride = 2 * int'(take_bits(5)) + 1;
        cycle(1'b0, 1'b1, 5'd0, core_pkg::BOOT_PC, 1'b0, 1'b0);
        idle_cycles(2);
        cycle(1'b0, 1'b0, 5'd0, 32'd0, 1'b1, 1'b0);
        idle_cycles(1);
        for (int i = 0; i < 64; i++) begin
            ofs = (((i + stride) % 64) - i) * 4;
            load_word(i, make_jal(21'(ofs), 5'd1), ofs);
        end
        cycle(1'b1, 1'b0, 5'd0, 32'd0, 1'b0, 1'b1);
        seen    = '0;
        visited = 0;
        n_cyc   = 0;
        while (visited < 64 && n_cyc < 200) begin
            cycle(rand_ready(), 1'b0, 5'd0, 32'd0, 1'b0, 1'b0);
            n_cyc++;
            if (xfer && !seen[xfer_pc[7:2]]) begin
                seen[xfer_pc[7:2]] = 1'b1;
                visited++;
            end
        end
        if (visited != 64) begin
            note_failure("jump chain did not reach every word");
        end
        end_test();

        $display("Summary: %0d tests, %0d checks, %0d mismatches", n_tests, n_checks, n_errs);
        if (n_errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(TOTAL_CYC * 2 * 10);
        $display("Timeout: tests did not finish within %0d cycles", TOTAL_CYC * 2);
        $display("Errors found");
        $finish;
    end

endmodule

// File: frontend_sva.sv
`timescale 1ns/100ps

module frontend_sva (
    input logic                      clk,
    input logic                      reset,
    input logic                      nuke,
    input logic                      resume_fetch,
    input logic                      nuke_pdg,
    input logic                      br_mispred_ql,
    input logic                      valid_fe1,
    input logic                      req_valid,
    input logic                      decode_ready,
    input logic                      br_mispred_valid,
    input fe_pkg::t_fsm_fe           state,
    input logic [core_pkg::XLEN-1:0] pc
);

    // Pending window opens on a mispredict and lasts until the nuke
    a_quiet_in_nuke: assert property (@(posedge clk) disable iff (reset)
        (br_mispred_ql || (nuke_pdg && !nuke)) |=> !valid_fe1)
        else $error("valid_fe1 high while a nuke is pending");

    a_req_in_fetch: assert property (@(posedge clk) disable iff (reset)
        (state == fe_pkg::FE_PDG_NUKE && !resume_fetch) |=> !req_valid)
        else $error("req_valid high outside FE_REQ_IC");

    // Stalled by decode, unless a mispredict redirects
    a_pc_hold: assert property (@(posedge clk) disable iff (reset)
        (valid_fe1 && !decode_ready && !br_mispred_valid) |=> $stable(pc))
        else $error("PC moved while decode stalled");

endmodule

bind fe_ctl frontend_sva sva0 (
    .clk              (clk),
    .reset            (reset),
    .nuke             (nuke),
    .resume_fetch     (resume_fetch),
    .nuke_pdg         (nuke_pdg),
    .br_mispred_ql    (br_mispred_ql),
    .valid_fe1        (valid_fe1),
    .req_valid        (req_valid),
    .decode_ready     (decode_ready),
    .br_mispred_valid (br_mispred_valid),
    .state            (state),
    .pc               (pc)
);

// File: frontend_top.sv
`timescale 1ns/100ps

module frontend_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          load_en,
    input  logic [core_pkg::XLEN-1:0]     load_addr,
    input  logic [core_pkg::XLEN-1:0]     load_data,
    input  logic                          nuke,
    input  logic                          resume_fetch,
    input  logic [core_pkg::ROB_ID_W-1:0] oldest_robid,
    input  logic                          br_mispred_valid,
    input  logic [core_pkg::ROB_ID_W-1:0] br_mispred_robid,
    input  logic [core_pkg::XLEN-1:0]     br_mispred_restore_pc,
    input  logic                          decode_ready,
    output logic                          valid_fe1,
    output logic [core_pkg::XLEN-1:0]     instr_fe1,
    output logic [core_pkg::XLEN-1:0]     pc_fe1,
    output logic [core_pkg::XLEN-1:0]     pc_nxt_fe1
);

    logic                                              req_valid;
    logic [core_pkg::XLEN-1:0]                         req_addr;
    logic [fe_pkg::NUM_BANKS-1:0]                      bank_hit;    // Indexed by bank number
    logic [fe_pkg::NUM_BANKS-1:0][core_pkg::XLEN-1:0]  bank_instr;
    logic                                              rsp_valid;
    logic [core_pkg::XLEN-1:0]                         rsp_instr;
    logic [core_pkg::XLEN-1:0]                         rsp_pc;
    fe_pkg::t_instr_class                              rsp_class;

    fe_ctl fe_ctl0 (
        .clk                   (clk),
        .reset                 (reset),
        .nuke                  (nuke),
        .resume_fetch          (resume_fetch),
        .oldest_robid          (oldest_robid),
        .br_mispred_valid      (br_mispred_valid),
        .br_mispred_robid      (br_mispred_robid),
        .br_mispred_restore_pc (br_mispred_restore_pc),
        .rsp_valid             (rsp_valid),
        .rsp_instr             (rsp_instr),
        .rsp_pc                (rsp_pc),
        .rsp_class             (rsp_class),
        .decode_ready          (decode_ready),
        .req_valid             (req_valid),
        .req_addr              (req_addr),
        .valid_fe1             (valid_fe1),
        .instr_fe1             (instr_fe1),
        .pc_fe1                (pc_fe1),
        .pc_nxt_fe1            (pc_nxt_fe1)
    );

    // One bank per word slot within a 16-byte line
    for (genvar b = 0; b < fe_pkg::NUM_BANKS; b++) begin : g_bank
        imem_bank #(
            .BANK_IDX (b)
        ) bank (
            .clk        (clk),
            .load_en    (load_en),
            .load_addr  (load_addr),
            .load_data  (load_data),
            .req_valid  (req_valid),
            .req_addr   (req_addr),
            .bank_hit   (bank_hit[b]),
            .bank_instr (bank_instr[b])
        );
    end

    fetch_merge merge0 (
        .req_addr   (req_addr),
        .bank_hit   (bank_hit),
        .bank_instr (bank_instr),
        .rsp_valid  (rsp_valid),
        .rsp_instr  (rsp_instr),
        .rsp_pc     (rsp_pc),
        .rsp_class  (rsp_class)
    );

endmodule

// File: fe_ctl.sv
`timescale 1ns/100ps

module fe_ctl (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          nuke,
    input  logic                          resume_fetch,
    input  logic [core_pkg::ROB_ID_W-1:0] oldest_robid,
    input  logic                          br_mispred_valid,
    input  logic [core_pkg::ROB_ID_W-1:0] br_mispred_robid,
    input  logic [core_pkg::XLEN-1:0]     br_mispred_restore_pc,
    input  logic                          rsp_valid,
    input  logic [core_pkg::XLEN-1:0]     rsp_instr,
    input  logic [core_pkg::XLEN-1:0]     rsp_pc,
    input  fe_pkg::t_instr_class          rsp_class,
    input  logic                          decode_ready,
    output logic                          req_valid,
    output logic [core_pkg::XLEN-1:0]     req_addr,
    output logic                          valid_fe1,
    output logic [core_pkg::XLEN-1:0]     instr_fe1,
    output logic [core_pkg::XLEN-1:0]     pc_fe1,
    output logic [core_pkg::XLEN-1:0]     pc_nxt_fe1
);

    fe_pkg::t_fsm_fe                state;
    fe_pkg::t_fsm_fe                state_nxt;
    logic                           nuke_pdg;       // Waiting for the nuke after a mispredict
    logic                           br_mispred_pdg;
    logic [core_pkg::ROB_ID_W-1:0]  held_robid;     // Id of the mispredict being recovered
    logic                           br_mispred_ql;
    logic                           adv_pc;
    logic                           pred_tkn;
    logic [core_pkg::XLEN-1:0]      pred_pc_nxt;
    logic [core_pkg::XLEN-1:0]      pc;
    logic [core_pkg::XLEN-1:0]      pc_nxt;

    // Only an older mispredict may override one already in flight
    assign br_mispred_ql = br_mispred_valid &
        (~br_mispred_pdg | core_pkg::robid_older(br_mispred_robid, held_robid, oldest_robid));

    always_comb begin
        state_nxt = state;
        case (state)
            fe_pkg::FE_IDLE: begin
                state_nxt = fe_pkg::FE_REQ_IC;
            end
            fe_pkg::FE_REQ_IC: begin
                if (nuke_pdg || nuke) begin
                    state_nxt = fe_pkg::FE_PDG_NUKE;
                end
            end
            fe_pkg::FE_PDG_NUKE: begin
                if (resume_fetch) begin
                    state_nxt = fe_pkg::FE_REQ_IC;  // Backend is clean again
                end
            end
            default: begin
                state_nxt = fe_pkg::FE_IDLE;
            end
        endcase
    end

    bpu bpu0 (
        .pc          (pc),
        .instr       (rsp_instr),
        .instr_class (rsp_class),
        .pred_tkn    (pred_tkn),
        .pred_pc_nxt (pred_pc_nxt)
    );

    assign adv_pc = valid_fe1 & decode_ready;  // Transfer to decode

    // Restore PC wins over anything fetched this cycle
    always_comb begin
        if (br_mispred_ql) begin
            pc_nxt = br_mispred_restore_pc;
        end else if (adv_pc && pred_tkn) begin
            pc_nxt = pred_pc_nxt;
        end else if (adv_pc) begin
            pc_nxt = pc + 32'd4;
        end else begin
            pc_nxt = pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= fe_pkg::FE_IDLE;
            nuke_pdg       <= 1'b0;
            br_mispred_pdg <= 1'b0;
            pc             <= core_pkg::BOOT_PC;
        end else begin
            state          <= state_nxt;
            nuke_pdg       <= (nuke_pdg & ~nuke) | br_mispred_ql;
            br_mispred_pdg <= ~nuke & (br_mispred_pdg | br_mispred_ql);
            pc             <= pc_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (br_mispred_ql) begin
            held_robid <= br_mispred_robid;
        end
    end

    assign req_valid = (state == fe_pkg::FE_REQ_IC);
    assign req_addr  = pc;

    // Outputs to decode
    assign valid_fe1  = (state == fe_pkg::FE_REQ_IC) & rsp_valid & ~nuke_pdg;
    assign instr_fe1  = rsp_instr;
    assign pc_fe1     = rsp_pc;
    assign pc_nxt_fe1 = pc_nxt;

endmodule

// File: fetch_merge.sv
`timescale 1ns/100ps

module fetch_merge (
    input  logic [core_pkg::XLEN-1:0]                         req_addr,
    input  logic [fe_pkg::NUM_BANKS-1:0]                      bank_hit,
    input  logic [fe_pkg::NUM_BANKS-1:0][core_pkg::XLEN-1:0]  bank_instr,
    output logic                                              rsp_valid,
    output logic [core_pkg::XLEN-1:0]                         rsp_instr,
    output logic [core_pkg::XLEN-1:0]                         rsp_pc,
    output fe_pkg::t_instr_class                              rsp_class
);

    logic [6:0] opcode;

    assign rsp_valid = |bank_hit;
    assign rsp_pc    = req_addr;  // Banks return in the request cycle

    // At most one bank hits, so an AND-OR mux is enough
    always_comb begin
        rsp_instr = '0;
        for (int i = 0; i < fe_pkg::NUM_BANKS; i++) begin
            rsp_instr = rsp_instr | (bank_instr[i] & {core_pkg::XLEN{bank_hit[i]}});
        end
    end

    assign opcode = rsp_instr[6:0];

    // Predecode for the predictor
    always_comb begin
        case (opcode)
            fe_pkg::OPC_JAL: begin
                rsp_class = fe_pkg::IC_JAL;
            end
            fe_pkg::OPC_BRANCH: begin
                rsp_class = fe_pkg::IC_BRANCH;  // Not predicted yet
            end
            default: begin
                rsp_class = fe_pkg::IC_OTHER;
            end
        endcase
    end

endmodule

// File: imem_bank.sv
`timescale 1ns/100ps

module imem_bank #(
    parameter int BANK_IDX = 0
) (
    input  logic                      clk,
    input  logic                      load_en,
    input  logic [core_pkg::XLEN-1:0] load_addr,
    input  logic [core_pkg::XLEN-1:0] load_data,
    input  logic                      req_valid,
    input  logic [core_pkg::XLEN-1:0] req_addr,
    output logic                      bank_hit,
    output logic [core_pkg::XLEN-1:0] bank_instr
);

    localparam logic [fe_pkg::BANK_SEL_W-1:0] MY_SEL = fe_pkg::BANK_SEL_W'(BANK_IDX);

    logic [core_pkg::XLEN-1:0]       mem [fe_pkg::BANK_DEPTH];
    logic [fe_pkg::BANK_ADDR_W-1:0]  load_word;
    logic [fe_pkg::BANK_ADDR_W-1:0]  req_word;
    logic                            load_sel;

    assign load_sel  = (load_addr[fe_pkg::BANK_SEL_LSB +: fe_pkg::BANK_SEL_W] == MY_SEL);
    assign load_word = load_addr[fe_pkg::BANK_ADDR_LSB +: fe_pkg::BANK_ADDR_W];
    assign req_word  = req_addr[fe_pkg::BANK_ADDR_LSB +: fe_pkg::BANK_ADDR_W];

    always_ff @(posedge clk) begin
        if (load_en && load_sel) begin
            mem[load_word] <= load_data;
        end
    end

    // Zero-latency read, hit only for this bank's slice of the PC
    assign bank_hit   = req_valid & (req_addr[fe_pkg::BANK_SEL_LSB +: fe_pkg::BANK_SEL_W] == MY_SEL);
    assign bank_instr = mem[req_word];

endmodule

// File: bpu.sv
`timescale 1ns/100ps

module bpu (
    input  logic [core_pkg::XLEN-1:0] pc,
    input  logic [core_pkg::XLEN-1:0] instr,
    input  fe_pkg::t_instr_class      instr_class,
    output logic                      pred_tkn,
    output logic [core_pkg::XLEN-1:0] pred_pc_nxt
);

    logic [core_pkg::XLEN-1:0] j_imm;

    // J-type immediate, bit 0 always zero
    assign j_imm = {
        {12{instr[31]}},
        instr[19:12],
        instr[20],
        instr[30:21],
        1'b0
    };

    // Static policy for now
    // JAL is always taken and its target is known at fetch
    assign pred_tkn    = (instr_class == fe_pkg::IC_JAL);
    assign pred_pc_nxt = pc + j_imm;

endmodule

// File: fe_pkg.sv
package fe_pkg;

    // Word-interleaved bank geometry
    localparam int NUM_BANKS     = 4;
    localparam int BANK_SEL_W    = 2;
    localparam int BANK_SEL_LSB  = 2;                        // PC bits 3:2
    localparam int BANK_DEPTH    = 16;
    localparam int BANK_ADDR_W   = 4;
    localparam int BANK_ADDR_LSB = BANK_SEL_LSB + BANK_SEL_W; // PC bits 7:4

    // Major opcodes seen by predecode
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef enum logic [1:0] {
        FE_IDLE,
        FE_REQ_IC,
        FE_PDG_NUKE
    } t_fsm_fe;

    typedef enum logic [1:0] {
        IC_OTHER,
        IC_JAL,
        IC_BRANCH
    } t_instr_class;

endpackage

// File: core_pkg.sv
package core_pkg;

    localparam int XLEN     = 32;
    localparam int ROB_ID_W = 5;  // Top bit is the wrap bit

    localparam logic [XLEN-1:0] BOOT_PC = 32'h0000_0100;

    // True when id a is older than id b.
    // Both ids are measured as a distance from the oldest id in flight.
    // The subtraction wraps modulo the id range, so the wrap bit needs no
    // special handling.
    function automatic logic robid_older(
        input logic [ROB_ID_W-1:0] a,
        input logic [ROB_ID_W-1:0] b,
        input logic [ROB_ID_W-1:0] oldest
    );
        logic [ROB_ID_W-1:0] dist_a;
        logic [ROB_ID_W-1:0] dist_b;
        dist_a = a - oldest;
        dist_b = b - oldest;
        return dist_a < dist_b;  // Closer to oldest means older
    endfunction

endpackage
